/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_pipelined_processor
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* cpu_pkg.sv */
package cpu_pkg;

    typedef logic [15:0] word_t;    // Data and instruction word
    typedef logic [2:0]  reg_idx_t; // Register number
    typedef logic [5:0]  addr_t;    // Instruction memory address
    typedef logic [4:0]  opcode_t;

    // Carry, zero, negative from msb down
    typedef logic [2:0] flags_t;

    localparam int FLAG_C = 2;
    localparam int FLAG_Z = 1;
    localparam int FLAG_N = 0;

    // Opcode map, bits [15:11] of the instruction
    localparam opcode_t OP_NOP  = 5'b00000;
    localparam opcode_t OP_SETC = 5'b00001;
    localparam opcode_t OP_NOT  = 5'b00011;
    localparam opcode_t OP_INC  = 5'b00101;
    localparam opcode_t OP_LDM  = 5'b01110; // Immediate in the next word
    localparam opcode_t OP_ADD  = 5'b11001;
    localparam opcode_t OP_SUB  = 5'b11010;
    localparam opcode_t OP_AND  = 5'b11011;
    localparam opcode_t OP_OR   = 5'b11100;
    localparam opcode_t OP_MOV  = 5'b11101;
    localparam opcode_t OP_HLT  = 5'b11111;

    // Decoded op queue
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1); // Holds 0 to FIFO_DEPTH

    // One decoded instruction, 27 bits
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        word_t    imm;    // LDM only
    } decoded_op_t;

    // Wishbone master request, 25 bits
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        word_t dat;  // Write data
    } wb_req_t;

    // Fetch FSM states
    typedef enum logic [2:0] {
        FS_IDLE,
        FS_FETCH,
        FS_DECODE,
        FS_IMM,
        FS_HALT
    } fetch_state_t;

endpackage

/* exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_pkg::decoded_op_t pop_op,
    input  logic                 pop_valid,
    output logic                 pop_ready,
    input  cpu_pkg::reg_idx_t    reg_sel,
    output cpu_pkg::word_t       reg_value,
    output cpu_pkg::flags_t      flags,
    output logic [15:0]          retired,
    output logic                 done
);
    import cpu_pkg::*;

    word_t regs [2**$bits(reg_idx_t)]; // R0 to R7

    logic   fire;       // Op accepted this cycle
    word_t  rd_val;
    word_t  rs_val;
    word_t  result;
    logic   carry;
    logic   wr_en;      // Result goes to rd
    logic   upd_zn;     // Zero and negative follow result
    flags_t flags_nxt;

    assign pop_ready = !done; // Stop draining after HLT
    assign fire      = pop_valid && pop_ready;

    // Operands read at execute time
    assign rd_val = regs[pop_op.rd];
    assign rs_val = regs[pop_op.rs];

    // Observation port
    assign reg_value = regs[reg_sel];

    always_comb begin
        result = rd_val;
        carry  = flags[FLAG_C]; // Kept unless the op sets it
        wr_en  = 1'b0;
        upd_zn = 1'b0;
        case (pop_op.opcode)
            OP_NOT: begin
                result = ~rd_val;
                wr_en  = 1'b1;
                upd_zn = 1'b1;
            end
            OP_INC: begin
                {carry, result} = {1'b0, rd_val} + 17'd1;
                wr_en  = 1'b1;
                upd_zn = 1'b1;
            end
            OP_ADD: begin
                {carry, result} = {1'b0, rd_val} + {1'b0, rs_val};
                wr_en  = 1'b1;
                upd_zn = 1'b1;
            end
            OP_SUB: begin
                {carry, result} = {1'b0, rd_val} - {1'b0, rs_val}; // Msb is borrow
                wr_en  = 1'b1;
                upd_zn = 1'b1;
            end
            OP_AND: begin
                result = rd_val & rs_val;
                wr_en  = 1'b1;
                upd_zn = 1'b1;
            end
            OP_OR: begin
                result = rd_val | rs_val;
                wr_en  = 1'b1;
                upd_zn = 1'b1;
            end
            OP_MOV: begin
                result = rs_val; // No flag change
                wr_en  = 1'b1;
            end
            OP_LDM: begin
                result = pop_op.imm;
                wr_en  = 1'b1;
            end
            OP_SETC: carry = 1'b1;
            default: begin
                // NOP, HLT and unknown opcodes
            end
        endcase

        flags_nxt         = flags;
        flags_nxt[FLAG_C] = carry;
        if (upd_zn) begin
            flags_nxt[FLAG_Z] = (result == '0);
            flags_nxt[FLAG_N] = result[15]; // Sign bit
        end
    end

    // Write, flags and count share one edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < $size(regs); i++) begin
                regs[i] <= '0;
            end
            flags   <= '0;
            retired <= '0;
            done    <= 1'b0;
        end else if (fire) begin
            if (wr_en) begin
                regs[pop_op.rd] <= result;
            end
            flags   <= flags_nxt;
            retired <= retired + 16'd1; // Every op counts
            if (pop_op.opcode == OP_HLT) begin
                done <= 1'b1; // Sticky until reset
            end
        end
    end

endmodule

/* fetch_decode.sv */
`timescale 1ns/1ps

module fetch_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 run,
    output cpu_pkg::addr_t       fetch_addr,
    input  cpu_pkg::word_t       fetch_data,
    output cpu_pkg::decoded_op_t push_op,
    output logic                 push_valid,
    input  logic                 push_ready
);
    import cpu_pkg::*;

    fetch_state_t state, state_nxt;
    addr_t        pc;       // Word being fetched or decoded
    decoded_op_t  held_op;  // LDM fields while the immediate arrives

    opcode_t  dec_opcode;
    reg_idx_t dec_rd;
    reg_idx_t dec_rs;
    logic     is_ldm;
    logic     push_fire;

    // Instruction fields, low 5 bits unused
    assign dec_opcode = fetch_data[15:11];
    assign dec_rd     = fetch_data[10:8];
    assign dec_rs     = fetch_data[7:5];
    assign is_ldm     = (dec_opcode == OP_LDM);

    assign push_fire = push_valid && push_ready;

    always_comb begin
        state_nxt  = state;
        fetch_addr = pc;   // Re-read same word so a stall keeps data steady
        push_valid = 1'b0;
        push_op    = '{opcode: dec_opcode, rd: dec_rd, rs: dec_rs, imm: '0};
        case (state)
            FS_IDLE: begin
                if (run) begin
                    state_nxt = FS_FETCH;
                end
            end
            FS_FETCH: begin
                state_nxt = FS_DECODE; // Memory latency
            end
            FS_DECODE: begin
                if (is_ldm) begin
                    // Start reading the immediate word now
                    fetch_addr = pc + addr_t'(1);
                    state_nxt  = FS_IMM;
                end else begin
                    push_valid = 1'b1;
                    if (push_ready) begin
                        state_nxt = (dec_opcode == OP_HLT) ? FS_HALT : FS_FETCH;
                    end
                end
            end
            FS_IMM: begin
                push_valid  = 1'b1;
                push_op     = held_op;
                push_op.imm = fetch_data; // Word after LDM
                if (push_ready) begin
                    state_nxt = FS_FETCH;
                end
            end
            default: begin
                // FS_HALT, nothing more fetched
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FS_IDLE;
            pc    <= '0;
        end else begin
            state <= state_nxt;
            // Step past LDM opcode word and past each pushed word
            if ((state == FS_DECODE && is_ldm) || push_fire) begin
                pc <= pc + addr_t'(1);
            end
        end
    end

    // Keep LDM opcode and rd for the IMM cycle
    always_ff @(posedge clk) begin
        if (state == FS_DECODE) begin
            held_op <= push_op;
        end
    end

endmodule

/* instr_mem.sv */
`timescale 1ns/1ps

module instr_mem (
    input  logic             clk,
    input  logic             rst,
    input  cpu_pkg::wb_req_t wb_req,
    output logic             wb_ack,
    output cpu_pkg::word_t   wb_dat,
    input  cpu_pkg::addr_t   fetch_addr,
    output cpu_pkg::word_t   fetch_data
);
    import cpu_pkg::*;

    // Program store, one word per address
    word_t mem [2**$bits(addr_t)];

    logic wb_hit; // Valid Wishbone access this cycle

    // Ack already up means this access is done
    assign wb_hit = wb_req.cyc && wb_req.stb && !wb_ack;

    // Single cycle ack, raised the cycle after stb is seen
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_hit;
        end
    end

    always_ff @(posedge clk) begin
        // Program load lands on the ack edge
        if (wb_hit && wb_req.we) begin
            mem[wb_req.adr] <= wb_req.dat;
        end
        if (wb_hit) begin
            wb_dat <= mem[wb_req.adr]; // Readback, valid with ack
        end
        fetch_data <= mem[fetch_addr]; // One cycle fetch latency
    end

endmodule

/* op_fifo.sv */
`timescale 1ns/1ps

module op_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_pkg::decoded_op_t push_op,
    input  logic                 push_valid,
    output logic                 push_ready,
    output cpu_pkg::decoded_op_t pop_op,
    output logic                 pop_valid,
    input  logic                 pop_ready
);
    import cpu_pkg::*;

    decoded_op_t entries [FIFO_DEPTH]; // Ring storage

    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;  // Entries held
    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign push_ready = !full;
    assign pop_valid  = !empty;
    assign pop_op     = entries[rd_ptr]; // Head of queue

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_op;
        end
    end

endmodule

/* pipe_checker.sv */
`timescale 1ns/1ps

module pipe_checker (
    input logic clk,
    input logic rst,
    input logic wb_ack,
    input logic push_valid,
    input logic push_ready,
    input logic pop_valid,
    input logic pop_ready
);
    import cpu_pkg::*;

    int fail_count = 0; // Read by the testbench at the end
    int occupancy;      // Entries seen going in minus entries seen going out

    // Shadow count built from the two handshakes only
    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push_valid && push_ready)
                                   - int'(pop_valid && pop_ready);
        end
    end

    // Classic slave acks once per access
    ack_single: assert property (@(posedge clk) disable iff (rst) !(wb_ack && $past(wb_ack)))
        else begin
            $error("wb_ack high in two cycles in a row");
            fail_count++;
        end

    // No push accepted into a full queue
    no_push_full: assert property (@(posedge clk) disable iff (rst)
                                   (occupancy == FIFO_DEPTH) |-> !(push_valid && push_ready))
        else begin
            $error("push accepted while the FIFO is full");
            fail_count++;
        end

    no_pop_empty: assert property (@(posedge clk) disable iff (rst)
                                   (occupancy == 0) |-> !pop_valid)
        else begin
            $error("pop_valid high while the FIFO is empty");
            fail_count++;
        end

endmodule

bind instr_mem pipe_checker u_mem_rules (
    .clk(clk), .rst(rst), .wb_ack(wb_ack), .push_valid(1'b0), .push_ready(1'b0),
    .pop_valid(1'b0), .pop_ready(1'b0)
);

bind op_fifo pipe_checker u_fifo_rules (
    .clk(clk), .rst(rst), .wb_ack(1'b0), .push_valid(push_valid), .push_ready(push_ready),
    .pop_valid(pop_valid), .pop_ready(pop_ready)
);

/* pipelined_processor.sv */
`timescale 1ns/1ps

module pipelined_processor (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::wb_req_t  wb_req,   // Program load port
    input  logic              run,
    output logic              wb_ack,
    output cpu_pkg::word_t    wb_dat,
    input  cpu_pkg::reg_idx_t reg_sel,
    output cpu_pkg::word_t    reg_value,
    output cpu_pkg::flags_t   flags,
    output logic [15:0]       retired,
    output logic              done
);
    import cpu_pkg::*;

    // Fetch path
    addr_t fetch_addr;
    word_t fetch_data;

    // Producer side of the queue
    decoded_op_t push_op;
    logic        push_valid;
    logic        push_ready;

    // Consumer side
    decoded_op_t pop_op;
    logic        pop_valid;
    logic        pop_ready;

    instr_mem u_instr_mem (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_ack     (wb_ack),
        .wb_dat     (wb_dat),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    fetch_decode u_fetch_decode (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .push_op    (push_op),
        .push_valid (push_valid),
        .push_ready (push_ready)
    );

    op_fifo u_op_fifo (
        .clk        (clk),
        .rst        (rst),
        .push_op    (push_op),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .pop_op     (pop_op),
        .pop_valid  (pop_valid),
        .pop_ready  (pop_ready)
    );

    exec_unit u_exec_unit (
        .clk        (clk),
        .rst        (rst),
        .pop_op     (pop_op),
        .pop_valid  (pop_valid),
        .pop_ready  (pop_ready),
        .reg_sel    (reg_sel),
        .reg_value  (reg_value),
        .flags      (flags),
        .retired    (retired),
        .done       (done)
    );

endmodule

/* program_golden.txt */
# P <addr hex> <word hex> program word, R <reg> <value hex> expected register
# F <carry zero negative as hex> expected flags, N <decimal> expected retired count
P 00 c940
P 01 1900
P 02 0000
P 03 0000
P 04 ca20
P 05 1b00
P 06 7400
P 07 0040
P 08 0800
P 09 d420
P 0a db80
P 0b e540
P 0c 2a00
P 0d ee60
P 0e f800
R 0 0000
R 1 ffff
R 2 0000
R 3 0041
R 4 0041
R 5 ffff
R 6 0041
R 7 0000
# INC r2 wraps to zero so carry and zero end high
F 6
N 14

/* sim.f */
cpu_pkg.sv
instr_mem.sv
fetch_decode.sv
op_fifo.sv
exec_unit.sv
pipelined_processor.sv
pipe_checker.sv
tb_pipelined_processor.sv

/* tb_pipelined_processor.sv */
`timescale 1ns/1ps

module tb_pipelined_processor;
    import cpu_pkg::*;

    logic        clk;
    logic        rst;
    logic        run;
    wb_req_t     wb_req;
    logic        wb_ack;
    word_t       wb_dat;
    reg_idx_t    reg_sel;
    word_t       reg_value;
    flags_t      flags;
    logic [15:0] retired;
    logic        done;

    int value_errors;
    int other_errors;
    int checks;
    int cycles;
    int cycle_limit;     // Zero until the golden file is read
    int fd;
    int code;

    logic [7:0]       tag;       // Golden line tag, one character
    logic [8*128-1:0] line_buf;  // Rest of a comment line
    logic [31:0]      col_a;
    logic [31:0]      col_b;
    logic [31:0]      lfsr;

    addr_t       prog_addr[$];  // Program image from the golden file
    word_t       prog_word[$];
    reg_idx_t    exp_idx[$];    // Registers with an expected value
    word_t       exp_val[$];
    flags_t      exp_flags;
    logic [15:0] exp_retired;

    pipelined_processor UUT (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .run       (run),
        .wb_ack    (wb_ack),
        .wb_dat    (wb_dat),
        .reg_sel   (reg_sel),
        .reg_value (reg_value),
        .flags     (flags),
        .retired   (retired),
        .done      (done)
    );

    always #20 clk = ~clk; // 40 ns period

    // x^32 + x^22 + x^2 + x + 1, right shifting form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]); // One step per bit
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("error at %t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        end
    endtask

    task automatic load_golden;
        fd = $fopen("program_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open program_golden.txt");
            other_errors++;
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                code = 2;
                case (tag)
                    "#": code = ($fgets(line_buf, fd) > 0) ? 2 : 0; // Comment line
                    "P": begin
                        code = $fscanf(fd, "%h %h", col_a, col_b);
                        prog_addr.push_back(addr_t'(col_a));
                        prog_word.push_back(word_t'(col_b));
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", col_a, col_b);
                        exp_idx.push_back(reg_idx_t'(col_a));
                        exp_val.push_back(word_t'(col_b));
                    end
                    "F": code = 1 + $fscanf(fd, "%h", col_a);
                    "N": code = 1 + $fscanf(fd, "%d", col_b);
                    default: code = -1;
                endcase
                if (tag == "F") exp_flags = flags_t'(col_a);
                if (tag == "N") exp_retired = col_b[15:0];
                if (code != 2) begin
                    $display("golden file has a line that cannot be read, tag %c", tag);
                    other_errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // One classic cycle, held until ack
    task automatic wb_access(input logic we, input addr_t adr, input word_t dat,
                             output word_t rdata);
        int gap;
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do @(negedge clk); while (!wb_ack);
        rdata  = wb_dat;
        wb_req = '0;
        @(negedge clk);
        check("wb_ack", 32'd0, 32'(wb_ack)); // Single cycle ack
        take_random_bits(2, gap);
        repeat (gap) @(negedge clk);          // Idle 0 to 3 cycles
    endtask

    task automatic read_reg(input reg_idx_t idx, output word_t value);
        @(negedge clk);
        reg_sel = idx;
        #5 value = reg_value;
    endtask

    task automatic check_reset_state;
        word_t v;
        check("done", 32'd0, 32'(done));
        check("retired", 32'd0, 32'(retired));
        check("flags", 32'd0, 32'(flags));
        for (int i = 0; i < 8; i++) begin
            read_reg(reg_idx_t'(i), v);
            check($sformatf("r%0d after reset", i), 32'd0, 32'(v));
        end
    endtask

    task automatic load_and_verify_program;
        word_t rdata;
        foreach (prog_word[i]) wb_access(1'b1, prog_addr[i], prog_word[i], rdata);
        foreach (prog_word[i]) begin
            wb_access(1'b0, prog_addr[i], '0, rdata);
            check($sformatf("wb_dat mem[%0d]", prog_addr[i]), 32'(prog_word[i]), 32'(rdata));
        end
    endtask

    task automatic check_results;
        word_t v;
        foreach (exp_idx[i]) begin
            read_reg(exp_idx[i], v);
            check($sformatf("r%0d", exp_idx[i]), 32'(exp_val[i]), 32'(v));
        end
        check("flags", 32'(exp_flags), 32'(flags));
        check("retired", 32'(exp_retired), 32'(retired));
    endtask

    task automatic end_run;
        int assert_fails;
        assert_fails = UUT.u_instr_mem.u_mem_rules.fail_count
                     + UUT.u_op_fifo.u_fifo_rules.fail_count;
        $display("checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
                 checks, value_errors, other_errors, assert_fails);
        if (value_errors + other_errors + assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // Run limit from program length
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the program never finished", cycles);
            other_errors++;
            end_run();
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk          = 1'b0;
        rst          = 1'b1;
        run          = 1'b0;
        wb_req       = '0;
        reg_sel      = '0;
        value_errors = 0;
        other_errors = 0;
        checks       = 0;
        cycles       = 0;
        cycle_limit  = 0;
        lfsr         = 32'h7e36ebc9;
        load_golden();
        if (other_errors == 0) begin
            // Two accesses per word, write then readback
            cycle_limit = 8 * prog_word.size() + 10 * 2 * prog_word.size() + 100;
            repeat (2) @(negedge clk);
            rst = 1'b0;
            check_reset_state();
            load_and_verify_program();
            @(negedge clk);
            run = 1'b1;
            while (!done) @(negedge clk); // Timeout guards this
            check_results();
        end
        end_run();
    end

endmodule
